/* hw/sddr_pkg.sv */
package sddr_pkg;

// DRAM geometry
localparam int BANK_BITS          = 3;
localparam int ROW_BITS           = 14;
localparam int COL_BITS           = 10;
localparam int DATA_BITS          = 16;

localparam int BURST_LENGTH       = 8;
localparam int HALF_BURST_LENGTH  = BURST_LENGTH / 2;  // Beats per lane
localparam int OFFSET_BITS        = 1;                 // Byte select below the column

// A10 during READ/WRITE
localparam int AUTO_PRECHARGE_BIT = 10;

// Bits are CS_n, RAS_n, CAS_n, WE_n
typedef enum logic [3:0] {
    CMD_NOP      = 4'b0111,
    CMD_ACTIVATE = 4'b0011,
    CMD_READ     = 4'b0101,
    CMD_WRITE    = 4'b0100,
    CMD_REFRESH  = 4'b0001
} ddr_cmd_e;

typedef struct packed {
    logic [BANK_BITS-1:0]   bank;
    logic [ROW_BITS-1:0]    row;
    logic [COL_BITS-1:0]    col;
    logic [OFFSET_BITS-1:0] offset;
} host_addr_t;

// Word 0 sits in the low bits
typedef logic [BURST_LENGTH-1:0][DATA_BITS-1:0] burst_t;

typedef struct packed {
    host_addr_t addr;
    logic       write;
    burst_t     data;
} data_req_t;

typedef struct packed {
    ddr_cmd_e                        cmd;
    logic [BANK_BITS-1:0]            ba;
    logic [ROW_BITS+OFFSET_BITS-1:0] addr;  // Row on ACTIVATE, column on READ/WRITE
} phy_cmd_t;

endpackage

/* hw/sddr_refresh_timer.sv */
`timescale 1ns/1ps

module sddr_refresh_timer #(
    parameter int T_REFI = 60
) (
    input  logic ddr_clock_i,
    input  logic rst_n_i,
    input  logic refresh_ack_i,
    output logic refresh_req_o
);

localparam int CNT_BITS = $clog2(T_REFI + 1);

logic [CNT_BITS-1:0] cnt_q;

always_ff @(posedge ddr_clock_i) begin
    if (!rst_n_i) begin
        cnt_q         <= CNT_BITS'(T_REFI);
        refresh_req_o <= 1'b0;
    end else begin
        if (refresh_ack_i)
            refresh_req_o <= 1'b0;

        // Interval keeps running while a request waits
        if (cnt_q == '0) begin
            cnt_q         <= CNT_BITS'(T_REFI);
            refresh_req_o <= 1'b1;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end
end

endmodule

/* hw/sddr_bank_fsm.sv */
`timescale 1ns/1ps

module sddr_bank_fsm import sddr_pkg::*; #(
    parameter int T_RCD             = 5,
    parameter int T_RP              = 5,
    parameter int T_RFC             = 20,
    parameter int CAS_READ_LATENCY  = 5,
    parameter int CAS_WRITE_LATENCY = 5,
    parameter int WRITE_RECOVERY    = 5
) (
    input  logic      ddr_clock_i,
    input  logic      rst_n_i,
    input  logic      refresh_req_i,
    output logic      refresh_ack_o,
    input  logic      data_cmd_valid_i,
    input  data_req_t data_cmd_req_i,
    output logic      data_cmd_ack_o,
    output logic      data_rsp_valid_o,
    output burst_t    data_rsp_data_o,
    output phy_cmd_t  ddr3_cmd_o,
    output logic      ddr3_odt_o,
    input  burst_t    ddr3_dq_i,
    output logic      data_transfer_o,
    output logic      data_write_o,
    output logic      load_o,
    output burst_t    load_data_o
);

function automatic int max_of(int a, int b);
    return (a > b) ? a : b;
endfunction

localparam int WAIT_MAX  = max_of(max_of(max_of(T_RCD, T_RFC), T_RP + WRITE_RECOVERY),
                                  max_of(max_of(CAS_READ_LATENCY, CAS_WRITE_LATENCY),
                                         HALF_BURST_LENGTH));
localparam int WAIT_BITS = $clog2(WAIT_MAX + 1);

typedef enum logic [2:0] {
    ST_PRECHARGED,
    ST_ACTIVATE,
    ST_OP,
    ST_READ,
    ST_READ_END,
    ST_WRITE,
    ST_WRITE_END
} bank_state_e;

bank_state_e          state_q;
bank_state_e          state_d;
logic [WAIT_BITS-1:0] cnt_q;
logic [WAIT_BITS-1:0] cnt_d;
logic [WAIT_BITS-1:0] wait_val;
logic                 cnt_zero_q;
logic                 zero_d;
logic                 load_wait;
host_addr_t           addr_q;
logic                 write_q;
logic                 accept;
logic                 do_refresh;
logic                 op_issue;
logic                 write_begin;
logic                 xfer_end;
logic                 capture;
logic                 load_d;
phy_cmd_t             cmd_d;

always_comb begin
    state_d     = state_q;
    cnt_d       = cnt_q;
    zero_d      = cnt_zero_q;
    wait_val    = '0;
    load_wait   = 1'b0;
    accept      = 1'b0;
    do_refresh  = 1'b0;
    op_issue    = 1'b0;
    write_begin = 1'b0;
    xfer_end    = 1'b0;
    capture     = 1'b0;
    // Shifter loads one cycle ahead of the first beat
    load_d      = (state_q == ST_WRITE) && !cnt_zero_q && (cnt_q == 1);
    cmd_d       = '{cmd: CMD_NOP, ba: '0, addr: '0};

    if (!cnt_zero_q) begin
        cnt_d  = cnt_q - 1'b1;
        zero_d = (cnt_q == 1);
    end else begin
        case (state_q)
            ST_PRECHARGED: begin
                // An acked request is always taken
                if (data_cmd_valid_i && data_cmd_ack_o) begin
                    accept  = 1'b1;
                    state_d = ST_ACTIVATE;
                end else if (refresh_req_i && !refresh_ack_o) begin
                    do_refresh = 1'b1;
                    cmd_d.cmd  = CMD_REFRESH;
                    wait_val   = WAIT_BITS'(T_RFC);
                    load_wait  = 1'b1;
                end
            end
            ST_ACTIVATE: begin
                cmd_d.cmd                = CMD_ACTIVATE;
                cmd_d.ba                 = addr_q.bank;
                cmd_d.addr[ROW_BITS-1:0] = addr_q.row;
                state_d                  = ST_OP;
                wait_val                 = WAIT_BITS'(T_RCD);
                load_wait                = 1'b1;
            end
            ST_OP: begin
                op_issue                       = 1'b1;
                cmd_d.cmd                      = write_q ? CMD_WRITE : CMD_READ;
                cmd_d.ba                       = addr_q.bank;
                cmd_d.addr[COL_BITS-1:0]       = addr_q.col;
                cmd_d.addr[AUTO_PRECHARGE_BIT] = 1'b1;
                load_wait                      = 1'b1;
                if (write_q) begin
                    state_d  = ST_WRITE;
                    wait_val = WAIT_BITS'(CAS_WRITE_LATENCY - 1);
                    load_d   = (CAS_WRITE_LATENCY == 1);
                end else begin
                    state_d  = ST_READ;
                    wait_val = WAIT_BITS'(CAS_READ_LATENCY);
                end
            end
            ST_WRITE: begin
                write_begin = 1'b1;
                state_d     = ST_WRITE_END;
                wait_val    = WAIT_BITS'(HALF_BURST_LENGTH - 1);
                load_wait   = 1'b1;
            end
            ST_READ: begin
                state_d   = ST_READ_END;
                wait_val  = WAIT_BITS'(HALF_BURST_LENGTH - 1);
                load_wait = 1'b1;
            end
            ST_WRITE_END: begin
                xfer_end  = 1'b1;
                state_d   = ST_PRECHARGED;
                wait_val  = WAIT_BITS'(T_RP + WRITE_RECOVERY);
                load_wait = 1'b1;
            end
            ST_READ_END: begin
                xfer_end  = 1'b1;
                capture   = 1'b1;
                state_d   = ST_PRECHARGED;
                wait_val  = WAIT_BITS'(T_RP);
                load_wait = 1'b1;
            end
            default: state_d = ST_PRECHARGED;
        endcase

        if (load_wait) begin
            cnt_d  = wait_val;
            zero_d = (wait_val == '0);
        end
    end
end

always_ff @(posedge ddr_clock_i) begin
    if (!rst_n_i) begin
        state_q          <= ST_PRECHARGED;
        cnt_q            <= '0;
        cnt_zero_q       <= 1'b1;
        data_cmd_ack_o   <= 1'b0;
        refresh_ack_o    <= 1'b0;
        ddr3_cmd_o       <= '{cmd: CMD_NOP, ba: '0, addr: '0};
        ddr3_odt_o       <= 1'b0;
        data_transfer_o  <= 1'b0;
        data_write_o     <= 1'b0;
        data_rsp_valid_o <= 1'b0;
        load_o           <= 1'b0;
    end else begin
        state_q          <= state_d;
        cnt_q            <= cnt_d;
        cnt_zero_q       <= zero_d;
        // Ack only if idle and settled on the next cycle
        data_cmd_ack_o   <= (state_d == ST_PRECHARGED) && zero_d && !refresh_req_i;
        refresh_ack_o    <= do_refresh;
        ddr3_cmd_o       <= cmd_d;
        data_rsp_valid_o <= capture;
        load_o           <= load_d;

        if (op_issue) begin
            data_transfer_o <= 1'b1;
            ddr3_odt_o      <= write_q;  // Termination for writes only
        end
        if (write_begin)
            data_write_o <= 1'b1;
        if (xfer_end) begin
            data_transfer_o <= 1'b0;
            data_write_o    <= 1'b0;
            ddr3_odt_o      <= 1'b0;
        end
    end
end

always_ff @(posedge ddr_clock_i) begin
    if (accept) begin
        addr_q      <= data_cmd_req_i.addr;
        write_q     <= data_cmd_req_i.write;
        load_data_o <= data_cmd_req_i.data;
    end
    if (capture)
        data_rsp_data_o <= ddr3_dq_i;
end

endmodule

/* hw/sddr_burst_shifter.sv */
`timescale 1ns/1ps

module sddr_burst_shifter import sddr_pkg::*; (
    input  logic                      ddr_clock_i,
    input  logic                      rst_n_i,
    input  logic                      load_i,
    input  burst_t                    load_data_i,
    output logic [1:0][DATA_BITS-1:0] dq_o
);

for (genvar lane = 0; lane < 2; lane++) begin : g_lane
    logic [HALF_BURST_LENGTH-1:0][DATA_BITS-1:0] shift_q;

    always_ff @(posedge ddr_clock_i) begin
        if (!rst_n_i) begin
            shift_q <= '0;
        end else if (load_i) begin
            // Even words to lane 0, odd words to lane 1
            for (int i = 0; i < HALF_BURST_LENGTH; i++)
                shift_q[i] <= load_data_i[2*i+lane];
        end else begin
            shift_q <= shift_q >> DATA_BITS;  // Next beat toward the pins
        end
    end

    assign dq_o[lane] = shift_q[0];
end

endmodule

/* hw/sddr_ctrl_top.sv */
`timescale 1ns/1ps

module sddr_ctrl_top import sddr_pkg::*; #(
    parameter int T_RCD             = 5,
    parameter int T_RP              = 5,
    parameter int T_RFC             = 20,
    parameter int T_REFI            = 60,
    parameter int CAS_READ_LATENCY  = 5,
    parameter int CAS_WRITE_LATENCY = 5,
    parameter int WRITE_RECOVERY    = 5
) (
    input  logic                      ddr_clock_i,
    input  logic                      rst_n_i,

    input  logic                      data_cmd_valid_i,
    input  data_req_t                 data_cmd_req_i,
    output logic                      data_cmd_ack_o,
    output logic                      data_rsp_valid_o,
    output burst_t                    data_rsp_data_o,

    output phy_cmd_t                  ddr3_cmd_o,
    output logic                      ddr3_odt_o,
    output logic [1:0][DATA_BITS-1:0] ddr3_dq_o,
    input  burst_t                    ddr3_dq_i,
    output logic                      data_transfer_o,
    output logic                      data_write_o
);

logic   refresh_req;
logic   refresh_ack;
logic   burst_load;
burst_t burst_load_data;

sddr_refresh_timer #(
    .T_REFI(T_REFI)
) u_refresh_timer (
    .ddr_clock_i  (ddr_clock_i),
    .rst_n_i      (rst_n_i),
    .refresh_ack_i(refresh_ack),
    .refresh_req_o(refresh_req)
);

sddr_bank_fsm #(
    .T_RCD            (T_RCD),
    .T_RP             (T_RP),
    .T_RFC            (T_RFC),
    .CAS_READ_LATENCY (CAS_READ_LATENCY),
    .CAS_WRITE_LATENCY(CAS_WRITE_LATENCY),
    .WRITE_RECOVERY   (WRITE_RECOVERY)
) u_bank_fsm (
    .ddr_clock_i     (ddr_clock_i),
    .rst_n_i         (rst_n_i),
    .refresh_req_i   (refresh_req),
    .refresh_ack_o   (refresh_ack),
    .data_cmd_valid_i(data_cmd_valid_i),
    .data_cmd_req_i  (data_cmd_req_i),
    .data_cmd_ack_o  (data_cmd_ack_o),
    .data_rsp_valid_o(data_rsp_valid_o),
    .data_rsp_data_o (data_rsp_data_o),
    .ddr3_cmd_o      (ddr3_cmd_o),
    .ddr3_odt_o      (ddr3_odt_o),
    .ddr3_dq_i       (ddr3_dq_i),
    .data_transfer_o (data_transfer_o),
    .data_write_o    (data_write_o),
    .load_o          (burst_load),
    .load_data_o     (burst_load_data)
);

// Write data serializer
sddr_burst_shifter u_burst_shifter (
    .ddr_clock_i(ddr_clock_i),
    .rst_n_i    (rst_n_i),
    .load_i     (burst_load),
    .load_data_i(burst_load_data),
    .dq_o       (ddr3_dq_o)
);

endmodule

/* verif/sddr_ctrl_sva.sv */
`timescale 1ns/1ps

module sddr_ctrl_sva import sddr_pkg::*; #(
    parameter int T_RFC = 20
) (
    input logic     ddr_clock_i,
    input logic     rst_n_i,
    input logic     data_rsp_valid_o,
    input logic     ddr3_odt_o,
    input logic     data_write_o,
    input phy_cmd_t ddr3_cmd_o
);

rsp_pulse_a: assert property (@(posedge ddr_clock_i) disable iff (!rst_n_i)
    data_rsp_valid_o |=> !data_rsp_valid_o)
    else $error("response valid held longer than one cycle");

// Termination on for every write beat
odt_write_a: assert property (@(posedge ddr_clock_i) disable iff (!rst_n_i)
    data_write_o |-> ddr3_odt_o)
    else $error("write data driven without ODT");

refresh_gap_a: assert property (@(posedge ddr_clock_i) disable iff (!rst_n_i)
    (ddr3_cmd_o.cmd == CMD_REFRESH) |=> (ddr3_cmd_o.cmd != CMD_ACTIVATE) [*T_RFC])
    else $error("activate issued inside the refresh cycle time");

endmodule

bind sddr_ctrl_top sddr_ctrl_sva #(
    .T_RFC(T_RFC)
) u_sva (
    .ddr_clock_i     (ddr_clock_i),
    .rst_n_i         (rst_n_i),
    .data_rsp_valid_o(data_rsp_valid_o),
    .ddr3_odt_o      (ddr3_odt_o),
    .data_write_o    (data_write_o),
    .ddr3_cmd_o      (ddr3_cmd_o)
);

/* verif/sddr_ctrl_tb.sv */
`timescale 1ns/1ps

module sddr_ctrl_tb import sddr_pkg::*; ();

localparam int          CLK_PERIOD        = 40;
localparam int unsigned SEED              = 32'hec1d4140;
localparam int          T_RCD             = 3;
localparam int          T_RP              = 2;
localparam int          T_RFC             = 6;
localparam int          T_REFI            = 60;
localparam int          CAS_READ_LATENCY  = 3;
localparam int          CAS_WRITE_LATENCY = 3;
localparam int          WRITE_RECOVERY    = 2;
localparam int          WAIT_LIMIT        = 200;  // Cycles per wait
localparam int          KEY_BITS          = BANK_BITS + ROW_BITS + COL_BITS;

logic                      ddr_clock_i;
logic                      rst_n_i;
logic                      data_cmd_valid_i;
data_req_t                 data_cmd_req_i;
logic                      data_cmd_ack_o;
logic                      data_rsp_valid_o;
burst_t                    data_rsp_data_o;
phy_cmd_t                  ddr3_cmd_o;
logic                      ddr3_odt_o;
logic [1:0][DATA_BITS-1:0] ddr3_dq_o;
burst_t                    ddr3_dq_i;
logic                      data_transfer_o;
logic                      data_write_o;

int         value_errors;
int         other_errors;
bit         timed_out;
string      cur_name;
host_addr_t cur_addr;
burst_t     cur_data;

// DRAM model
burst_t               mem [bit [KEY_BITS-1:0]];
logic [ROW_BITS-1:0]  open_row [2**BANK_BITS];
logic [BANK_BITS-1:0] op_bank;
logic [COL_BITS-1:0]  op_col;
burst_t               wr_burst;
burst_t               rd_burst;
bit                   rd_pending;
bit                   write_prev;
bit                   refresh_prev;
bit                   odt_exp;  // From WRITE until the last beat
int                   beat;
int                   cyc;
int                   act_cyc;
int                   op_cyc;
int                   refresh_count;

sddr_ctrl_top #(
    .T_RCD            (T_RCD),
    .T_RP             (T_RP),
    .T_RFC            (T_RFC),
    .T_REFI           (T_REFI),
    .CAS_READ_LATENCY (CAS_READ_LATENCY),
    .CAS_WRITE_LATENCY(CAS_WRITE_LATENCY),
    .WRITE_RECOVERY   (WRITE_RECOVERY)
) dut0 (
    .ddr_clock_i     (ddr_clock_i),
    .rst_n_i         (rst_n_i),
    .data_cmd_valid_i(data_cmd_valid_i),
    .data_cmd_req_i  (data_cmd_req_i),
    .data_cmd_ack_o  (data_cmd_ack_o),
    .data_rsp_valid_o(data_rsp_valid_o),
    .data_rsp_data_o (data_rsp_data_o),
    .ddr3_cmd_o      (ddr3_cmd_o),
    .ddr3_odt_o      (ddr3_odt_o),
    .ddr3_dq_o       (ddr3_dq_o),
    .ddr3_dq_i       (ddr3_dq_i),
    .data_transfer_o (data_transfer_o),
    .data_write_o    (data_write_o)
);

initial begin
    ddr_clock_i = 1'b0;
    forever #(CLK_PERIOD / 2) ddr_clock_i = ~ddr_clock_i;
end

function automatic bit [KEY_BITS-1:0] mem_key(input logic [BANK_BITS-1:0] bank,
                                              input logic [ROW_BITS-1:0]  row,
                                              input logic [COL_BITS-1:0]  col);
    return {bank, row, col};
endfunction

task automatic report_mismatch(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
    value_errors++;
    $display("** Error: %s %s expected %0h actual %0h", cur_name, what, expected, actual);
endtask

function automatic bit probe(input int sel);
    case (sel)
        0:       return data_cmd_ack_o;
        1:       return data_transfer_o;
        default: return data_rsp_valid_o;
    endcase
endfunction

task automatic wait_level(input int sel, input bit level, input string what);
    int n;
    n = 0;
    while (probe(sel) != level && n < WAIT_LIMIT) begin
        @(negedge ddr_clock_i);
        n++;
    end
    assert (probe(sel) == level) else begin
        $display("%s: timed out waiting for %s", cur_name, what);
        other_errors++;
        timed_out = 1'b1;
    end
endtask

task automatic run_request(input bit wr, input burst_t expected);
    data_req_t req;
    req.addr  = cur_addr;
    req.write = wr;
    req.data  = wr ? expected : '0;
    @(posedge ddr_clock_i);
    data_cmd_valid_i <= 1'b1;
    data_cmd_req_i   <= req;
    @(negedge ddr_clock_i);
    wait_level(0, 1'b1, "request ack");
    if (timed_out)
        return;
    @(posedge ddr_clock_i);
    data_cmd_valid_i <= 1'b0;  // Accepted on this edge
    @(negedge ddr_clock_i);
    wait_level(1, 1'b1, "transfer start");
    if (!timed_out)
        wait_level(1, 1'b0, "transfer end");
    if (!wr && !timed_out) begin
        wait_level(2, 1'b1, "read response");
        if (!timed_out)
            assert (data_rsp_data_o == expected)
                else report_mismatch("read data", expected, data_rsp_data_o);
    end
endtask

task automatic idle_stretch();
    int start;
    start = refresh_count;
    repeat (3 * T_REFI) @(negedge ddr_clock_i);
    assert (refresh_count - start >= 2) else begin
        $display("%s: only %0d refresh commands in the idle stretch", cur_name,
                 refresh_count - start);
        other_errors++;
    end
endtask

always @(posedge ddr_clock_i)
    ddr3_dq_i <= rd_pending ? rd_burst : '0;  // Held until the response

always @(negedge ddr_clock_i) begin
    cyc++;
    if (rst_n_i) begin
        case (ddr3_cmd_o.cmd)
            CMD_ACTIVATE: begin
                act_cyc                 = cyc;
                open_row[ddr3_cmd_o.ba] = ddr3_cmd_o.addr[ROW_BITS-1:0];
                assert (ddr3_cmd_o.ba == cur_addr.bank)
                    else report_mismatch("activate bank", cur_addr.bank, ddr3_cmd_o.ba);
                assert (ddr3_cmd_o.addr[ROW_BITS-1:0] == cur_addr.row)
                    else report_mismatch("activate row", cur_addr.row,
                                         ddr3_cmd_o.addr[ROW_BITS-1:0]);
            end
            CMD_READ, CMD_WRITE: begin
                op_cyc  = cyc;
                op_bank = ddr3_cmd_o.ba;
                op_col  = ddr3_cmd_o.addr[COL_BITS-1:0];
                beat    = 0;
                assert (cyc - act_cyc == T_RCD + 1)
                    else report_mismatch("activate to command gap", T_RCD + 1, cyc - act_cyc);
                assert (op_bank == cur_addr.bank)
                    else report_mismatch("command bank", cur_addr.bank, op_bank);
                assert (op_col == cur_addr.col)
                    else report_mismatch("command column", cur_addr.col, op_col);
                assert (ddr3_cmd_o.addr[AUTO_PRECHARGE_BIT])
                    else report_mismatch("auto-precharge bit", 1, 0);
                if (ddr3_cmd_o.cmd == CMD_READ) begin
                    rd_burst   = '0;  // Unwritten locations read as zero
                    if (mem.exists(mem_key(op_bank, open_row[op_bank], op_col)))
                        rd_burst = mem[mem_key(op_bank, open_row[op_bank], op_col)];
                    rd_pending = 1'b1;
                end else begin
                    odt_exp = 1'b1;
                end
            end
            CMD_REFRESH: refresh_count++;
            default: ;
        endcase

        if (data_write_o) begin
            if (!write_prev)
                assert (cyc - op_cyc == CAS_WRITE_LATENCY)
                    else report_mismatch("write to data gap", CAS_WRITE_LATENCY, cyc - op_cyc);
            if (beat < HALF_BURST_LENGTH) begin
                assert (ddr3_dq_o[0] == cur_data[2*beat])
                    else report_mismatch($sformatf("lane 0 beat %0d", beat),
                                         cur_data[2*beat], ddr3_dq_o[0]);
                assert (ddr3_dq_o[1] == cur_data[2*beat+1])
                    else report_mismatch($sformatf("lane 1 beat %0d", beat),
                                         cur_data[2*beat+1], ddr3_dq_o[1]);
                wr_burst[2*beat]   = ddr3_dq_o[0];
                wr_burst[2*beat+1] = ddr3_dq_o[1];
            end
            beat++;
        end else if (write_prev) begin
            assert (beat == HALF_BURST_LENGTH)
                else report_mismatch("write beats", HALF_BURST_LENGTH, beat);
            mem[mem_key(op_bank, open_row[op_bank], op_col)] = wr_burst;
            odt_exp = 1'b0;
        end
        write_prev = data_write_o;

        assert (ddr3_odt_o == odt_exp)
            else report_mismatch("ODT", odt_exp, ddr3_odt_o);

        if (data_rsp_valid_o)
            rd_pending = 1'b0;
        if (refresh_prev) begin
            assert (!data_cmd_ack_o) else begin
                $display("%s: request acked while a refresh was waiting", cur_name);
                other_errors++;
            end
        end
        refresh_prev = dut0.refresh_req;
    end
end

initial begin
    int          fd;
    int          fields;
    int          bank;
    int          row;
    int          col;
    string       line;
    string       name;
    string       op;
    burst_t      data;

    void'($urandom(SEED));
    rst_n_i          = 1'b0;
    data_cmd_valid_i = 1'b0;
    data_cmd_req_i   = '0;
    ddr3_dq_i        = '0;
    rd_pending       = 1'b0;
    cur_name         = "reset";
    cur_addr         = '0;
    cur_data         = '0;

    repeat (3) @(posedge ddr_clock_i);
    rst_n_i <= 1'b1;
    @(negedge ddr_clock_i);
    assert (ddr3_cmd_o.cmd == CMD_NOP)
        else report_mismatch("command after reset", CMD_NOP, ddr3_cmd_o.cmd);
    assert ({data_cmd_ack_o, ddr3_odt_o, data_write_o, data_transfer_o,
             data_rsp_valid_o} == 5'b0)
        else report_mismatch("outputs after reset", 0, {data_cmd_ack_o, ddr3_odt_o,
                             data_write_o, data_transfer_o, data_rsp_valid_o});

    fd = $fopen("verif/sddr_ctrl_tests.txt", "r");
    if (fd == 0) begin
        $display("Could not open verif/sddr_ctrl_tests.txt");
        other_errors++;
    end else begin
        while (!timed_out && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            fields = $sscanf(line, "%s %s %d %d %d %h", name, op, bank, row, col, data);
            if (fields != 6) begin
                $display("Malformed line in test file: %s", line);
                other_errors++;
                continue;
            end
            cur_name        = name;
            cur_addr.bank   = BANK_BITS'(bank);
            cur_addr.row    = ROW_BITS'(row);
            cur_addr.col    = COL_BITS'(col);
            cur_addr.offset = '0;
            cur_data        = data;
            if (op == "i")
                idle_stretch();
            else
                run_request(op == "w", data);
            repeat ($urandom % 6) @(posedge ddr_clock_i);
        end
        $fclose(fd);
    end

    $display("Error counts: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
        $display("Finished with no errors");
    else
        $display("Finished with errors");
    $finish;
end

endmodule

/* verif/sddr_ctrl_tests.txt */
# name op(w=write r=read i=idle) bank row col burst (hex, word 7 first)
# read lines carry the burst expected back, idle lines wait 3 refresh intervals
wr_a w 0 5 8 a007a006a005a004a003a002a001a000
rd_a r 0 5 8 a007a006a005a004a003a002a001a000
wr_b w 3 16383 1016 b7b7b6b6b5b5b4b4b3b3b2b2b1b1b0b0
wr_c w 7 100 0 c007c006c005c004c003c002c001c000
rd_b r 3 16383 1016 b7b7b6b6b5b5b4b4b3b3b2b2b1b1b0b0
rd_empty r 2 77 64 00000000000000000000000000000000
wr_a2 w 0 5 8 0123456789abcdeffedcba9876543210
rd_a2 r 0 5 8 0123456789abcdeffedcba9876543210
idle_1 i 0 0 0 0
rd_c r 7 100 0 c007c006c005c004c003c002c001c000
rd_b2 r 3 16383 1016 b7b7b6b6b5b5b4b4b3b3b2b2b1b1b0b0
wr_d w 1 42 512 ffff0000ffff0000ffff0000ffff0000
wr_e w 1 43 512 00010002000400080010002000400080
rd_d r 1 42 512 ffff0000ffff0000ffff0000ffff0000
rd_e r 1 43 512 00010002000400080010002000400080
idle_2 i 0 0 0 0
rd_a3 r 0 5 8 0123456789abcdeffedcba9876543210
wr_f w 5 9000 1023 5a5aa5a55a5aa5a55a5aa5a55a5aa5a5
rd_f r 5 9000 1023 5a5aa5a55a5aa5a55a5aa5a55a5aa5a5
rd_d2 r 1 42 512 ffff0000ffff0000ffff0000ffff0000
wr_g w 6 1 1 fedcba98765432100123456789abcdef
rd_g r 6 1 1 fedcba98765432100123456789abcdef
rd_empty2 r 6 2 1 00000000000000000000000000000000

/* filelist.f */
hw/sddr_pkg.sv
hw/sddr_refresh_timer.sv
hw/sddr_bank_fsm.sv
hw/sddr_burst_shifter.sv
hw/sddr_ctrl_top.sv
verif/sddr_ctrl_sva.sv
verif/sddr_ctrl_tb.sv

/* Bender.yml */
package:
  name: sddr_ctrl

sources:
  - target: rtl
    files:
      - hw/sddr_pkg.sv
      - hw/sddr_refresh_timer.sv
      - hw/sddr_bank_fsm.sv
      - hw/sddr_burst_shifter.sv
      - hw/sddr_ctrl_top.sv
  - target: test
    files:
      - verif/sddr_ctrl_sva.sv
      - verif/sddr_ctrl_tb.sv
